// ==== src.f ====
verilog/img_pkt_pkg.sv
verilog/img_frame_framer.sv
verilog/img_async_fifo.sv
verilog/udp_pkt_sched.sv
verilog/img_ctrl_regs.sv
verilog/img_udp_top.sv
test/img_udp_assertions.sv
test/tb_img_udp_top.sv

// ==== test/img_udp_assertions.sv ====
// sampled on eth_tx_clk; legal packet lengths assume two bytes per pixel and an 8-byte header
`default_nettype none
`timescale 1ns/1ps

module img_udp_assertions #(
  parameter logic [15:0] h_pixel = 16'd640
) (
  input wire        eth_tx_clk,
  input wire        rst_n,
  input wire        rd_flush,
  input wire        udp_tx_done,
  input wire        udp_tx_start_en,
  input wire [15:0] udp_tx_byte_num
);
  localparam logic [15:0] line_len  = 16'(2 * h_pixel);      // one line
  localparam logic [15:0] first_len = 16'(2 * h_pixel + 8);  // header + line

  int   fail_cnt = 0;  // failure tally, summed into the closing line
  logic flush_q;
  logic open_pkt;      // start seen, no done or flush since

  // own model of an outstanding packet
  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      flush_q  <= 1'b0;
      open_pkt <= 1'b0;
    end else begin
      flush_q <= rd_flush;
      if (udp_tx_start_en)
        open_pkt <= 1'b1;
      else if (udp_tx_done || (rd_flush && !flush_q))  // done or frame abort
        open_pkt <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // scheduler checks
  // ------------------------------------------------------------------------
  start_one_cycle: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
    udp_tx_start_en |=> !udp_tx_start_en)
    else begin
      $error("udp_tx_start_en high for more than one cycle");
      fail_cnt++;
    end

  no_start_while_busy: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
    udp_tx_start_en |-> !open_pkt)
    else begin
      $error("udp_tx_start_en while a packet is still outstanding");
      fail_cnt++;
    end

  byte_num_legal: assert property (@(posedge eth_tx_clk) disable iff (!rst_n)
    (udp_tx_byte_num == 16'd0) || (udp_tx_byte_num == line_len) ||
    (udp_tx_byte_num == first_len))
    else begin
      $error("udp_tx_byte_num %0d is not a legal packet length", udp_tx_byte_num);
      fail_cnt++;
    end

  // second reset edge onward, flops have settled
  out_low_in_reset: assert property (@(posedge eth_tx_clk)
    (!rst_n && !$past(rst_n)) |-> (!udp_tx_start_en && udp_tx_byte_num == 16'd0))
    else begin
      $error("scheduler outputs not cleared during reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// ==== test/tb_img_udp_top.sv ====
// fixed for h 8, v 4 and a 64-byte fifo; the engine model reads exactly byte_num bytes per start
`default_nettype none
`timescale 1ns/1ps

module tb_img_udp_top;

  localparam logic [15:0] h_pix       = 16'd8;
  localparam logic [15:0] v_pix       = 16'd4;
  localparam int          fifo_aw     = 6;                 // 64 bytes
  localparam int          line_bytes  = 2 * h_pix;         // two bytes per pixel
  localparam int          first_bytes = line_bytes + 8;    // header + first line
  localparam logic [31:0] sync_word   = 32'hf05a_a50f;
  localparam logic [3:0]  ctrl_addr   = 4'h0;
  localparam logic [3:0]  status_addr = 4'h4;
  localparam int          blank_cyc   = 10;   // vsync high, > 8 eth cycles
  localparam int          lead_cyc    = 14;   // idle after vsync falls
  localparam int          gap_cyc     = 4;    // between lines
  localparam int          frame_cyc   = blank_cyc + lead_cyc + v_pix * (line_bytes + gap_cyc);
  localparam int          n_frames    = 5;
  localparam int          pclk_ns     = 20;
  localparam int          watchdog_ns = n_frames * frame_cyc * pclk_ns * 4;

  logic        cam_pclk   = 1'b0;
  logic        eth_tx_clk = 1'b0;
  logic        rst_n;
  logic        img_vsync;
  logic        img_data_en;
  logic [7:0]  img_data;
  logic        udp_tx_req;
  logic        udp_tx_done;
  logic        udp_tx_start_en;
  logic [7:0]  udp_tx_data;
  logic [15:0] udp_tx_byte_num;
  logic [3:0]  s_axil_awaddr;
  logic        s_axil_awvalid;
  logic        s_axil_awready;
  logic [31:0] s_axil_wdata;
  logic [3:0]  s_axil_wstrb;
  logic        s_axil_wvalid;
  logic        s_axil_wready;
  logic [1:0]  s_axil_bresp;
  logic        s_axil_bvalid;
  logic        s_axil_bready;
  logic [3:0]  s_axil_araddr;
  logic        s_axil_arvalid;
  logic        s_axil_arready;
  logic [31:0] s_axil_rdata;
  logic [1:0]  s_axil_rresp;
  logic        s_axil_rvalid;
  logic        s_axil_rready;

  logic [7:0]  exp_q [$];              // expected byte stream, header included
  logic [31:0] rng       = 32'h03a1_2174;
  bit          eng_on    = 1'b1;       // engine answers starts
  bit          eng_busy  = 1'b0;
  int          pkt_idx   = 0;          // packets done in current frame
  int          cur_test  = 0;
  int          start_cnt = 0;
  int          checks    = 0;
  int          errs [1:6] = '{default: 0};
  string       tname [1:6] = '{"registers", "disabled", "first_packet",
                               "later_packets", "frame_count", "overflow"};

  always #10 cam_pclk   = ~cam_pclk;     // 20 ns
  always #8  eth_tx_clk = ~eth_tx_clk;   // 16 ns

  img_udp_top #(.h_pixel(h_pix), .v_pixel(v_pix), .fifo_addr_w(fifo_aw)) i_img_udp_top (.*);

  bind udp_pkt_sched img_udp_assertions #(.h_pixel(h_pixel)) i_sched_chk (
    .eth_tx_clk, .rst_n, .rd_flush, .udp_tx_done, .udp_tx_start_en, .udp_tx_byte_num
  );

  always @(negedge eth_tx_clk) begin
    if (udp_tx_start_en === 1'b1) start_cnt++;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_val(input int t, input string what, input logic [31:0] exp,
                           input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %0h, actual %0h", tname[t], what, exp, act);
      errs[t]++;
    end
  endtask

  task automatic report_test(input int t);
    $display("test %0d %s: %0d errors", t, tname[t], errs[t]);
  endtask

  // ------------------------------------------------------------------------
  // axi4-lite master, aw and w together
  // ------------------------------------------------------------------------
  task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
    @(negedge cam_pclk);
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    do @(negedge cam_pclk); while (!s_axil_awready);
    check_val(cur_test, "wready with awready", 1, s_axil_wready);
    @(negedge cam_pclk);               // handshake edge now passed
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
    while (!s_axil_bvalid) @(negedge cam_pclk);
    check_val(cur_test, "bresp", 0, s_axil_bresp);   // always OKAY
  endtask

  task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
    @(negedge cam_pclk);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    do @(negedge cam_pclk); while (!s_axil_arready);
    @(negedge cam_pclk);
    s_axil_arvalid = 1'b0;
    while (!s_axil_rvalid) @(negedge cam_pclk);
    data = s_axil_rdata;
    check_val(cur_test, "rresp", 0, s_axil_rresp);
  endtask

  // ------------------------------------------------------------------------
  // camera model, one frame then blanking
  // ------------------------------------------------------------------------
  task automatic send_frame(input bit track);
    logic [7:0] b;
    pkt_idx = 0;
    if (track) begin
      for (int k = 3; k >= 0; k--) exp_q.push_back(sync_word[8*k +: 8]);  // msb first
      exp_q.push_back(h_pix[15:8]);
      exp_q.push_back(h_pix[7:0]);
      exp_q.push_back(v_pix[15:8]);
      exp_q.push_back(v_pix[7:0]);
    end
    @(negedge cam_pclk);
    img_vsync = 1'b0;
    repeat (lead_cyc) @(negedge cam_pclk);   // header slot
    for (int l = 0; l < v_pix; l++) begin
      for (int p = 0; p < line_bytes; p++) begin
        rng         = xorshift(rng);
        b           = rng[7:0];
        img_data    = b;
        img_data_en = 1'b1;
        if (track) exp_q.push_back(b);
        @(negedge cam_pclk);
      end
      img_data_en = 1'b0;
      repeat (gap_cyc) @(negedge cam_pclk);
    end
    // drain before blanking, flush would drop the rest
    while (track && (exp_q.size() != 0 || eng_busy)) @(negedge cam_pclk);
    img_vsync = 1'b1;
    repeat (blank_cyc) @(negedge cam_pclk);
  endtask

  // ------------------------------------------------------------------------
  // udp engine model
  // ------------------------------------------------------------------------
  initial begin : udp_engine
    int n;
    int t;
    forever begin
      do @(negedge eth_tx_clk); while (udp_tx_start_en !== 1'b1);
      if (eng_on) begin
        eng_busy = 1'b1;
        n = udp_tx_byte_num;
        t = (cur_test == 3 && pkt_idx > 0) ? 4 : cur_test;
        check_val(t, "byte_num", (pkt_idx == 0) ? first_bytes : line_bytes, n);
        udp_tx_req = (n > 0);
        for (int i = 0; i < n; i++) begin
          @(negedge eth_tx_clk);             // data from the req edge
          if (i == n - 1) udp_tx_req = 1'b0;
          if (exp_q.size() == 0) begin
            $display("test %s: byte received with no byte expected", tname[t]);
            errs[t]++;
          end else begin
            check_val(t, "data byte", exp_q.pop_front(), udp_tx_data);
          end
        end
        @(negedge eth_tx_clk);
        udp_tx_done = 1'b1;
        @(negedge eth_tx_clk);
        udp_tx_done = 1'b0;
        pkt_idx++;
        eng_busy = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("watchdog expired, the tests did not finish in time");
    $display("=== FAIL ===");
    $finish;
  end

  // ------------------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------------------
  initial begin : main_seq
    logic [31:0] rd;
    int          base;
    int          total;
    rst_n          = 1'b0;
    img_vsync      = 1'b1;    // start in blanking
    img_data_en    = 1'b0;
    img_data       = 8'h00;
    udp_tx_req     = 1'b0;
    udp_tx_done    = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = 4'hf;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b1;    // responses taken at once
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b1;
    repeat (5) @(posedge cam_pclk);
    @(negedge cam_pclk);
    rst_n = 1'b1;
    repeat (3) @(negedge cam_pclk);

    cur_test = 1;
    axil_read(ctrl_addr, rd);
    check_val(1, "ctrl after reset", 32'h0, rd);
    axil_read(status_addr, rd);
    check_val(1, "status after reset", 32'h0, rd);
    axil_write(ctrl_addr, 32'h1);
    axil_read(ctrl_addr, rd);
    check_val(1, "ctrl enable readback", 32'h1, rd);
    report_test(1);

    cur_test = 2;
    axil_write(ctrl_addr, 32'h0);
    base = start_cnt;
    send_frame(1'b0);
    check_val(2, "starts while disabled", 0, start_cnt - base);
    report_test(2);

    cur_test = 3;                      // later packets land in test 4
    axil_write(ctrl_addr, 32'h1);
    send_frame(1'b1);
    check_val(4, "packets per frame", v_pix, pkt_idx);
    report_test(3);
    report_test(4);

    cur_test = 5;
    send_frame(1'b1);
    send_frame(1'b1);
    axil_read(status_addr, rd);
    check_val(5, "frame count", 3, rd[31:16]);
    report_test(5);

    cur_test = 6;
    eng_on = 1'b0;                     // fifo fills, 72 bytes into 64
    send_frame(1'b0);
    eng_on = 1'b1;
    axil_read(status_addr, rd);
    check_val(6, "overflow flag set", 1, rd[0]);
    axil_write(ctrl_addr, 32'h3);      // enable kept, flag cleared
    axil_read(status_addr, rd);
    check_val(6, "overflow flag cleared", 0, rd[0]);
    report_test(6);

    total = i_img_udp_top.i_sched.i_sched_chk.fail_cnt;
    for (int t = 1; t <= 6; t++) total += errs[t];
    $display("tests 6, checks %0d, errors %0d, assertion failures %0d",
             checks, total - i_img_udp_top.i_sched.i_sched_chk.fail_cnt,
             i_img_udp_top.i_sched.i_sched_chk.fail_cnt);
    if (total == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/img_async_fifo.sv ====
// fifo_addr_w >= 2; flush must stay high long enough to reach both clock domains
`default_nettype none
`timescale 1ns/1ps

module img_async_fifo #(
  parameter int unsigned fifo_addr_w = 11
) (
  input  wire                    cam_pclk,
  input  wire                    eth_tx_clk,
  input  wire                    rst_n,
  input  wire                    flush_req,
  input  wire                    wr_en,
  input  wire  [7:0]             wr_data,
  output logic                   overflow,
  input  wire                    rd_en,
  output logic [7:0]             rd_data,
  output logic [fifo_addr_w:0]   fill_level,
  output logic                   rd_flush
);
  localparam int unsigned depth = 1 << fifo_addr_w;

  logic [7:0]           mem [depth];

  // write domain
  logic                 wf_d0;
  logic                 wr_flush;
  logic [fifo_addr_w:0] wr_bin;
  logic [fifo_addr_w:0] wr_gray;
  logic [fifo_addr_w:0] wr_bin_nxt;
  logic [fifo_addr_w:0] rg_d0;
  logic [fifo_addr_w:0] rg_sync;
  logic                 full;

  // read domain
  logic                 rf_d0;
  logic [fifo_addr_w:0] rd_bin;
  logic [fifo_addr_w:0] rd_gray;
  logic [fifo_addr_w:0] rd_bin_nxt;
  logic [fifo_addr_w:0] wg_d0;
  logic [fifo_addr_w:0] wg_sync;
  logic                 empty;

  function automatic logic [fifo_addr_w:0] gray2bin(input logic [fifo_addr_w:0] g);
    logic [fifo_addr_w:0] b;
    b[fifo_addr_w] = g[fifo_addr_w];
    for (int i = fifo_addr_w - 1; i >= 0; i--)
      b[i] = b[i+1] ^ g[i];
    return b;
  endfunction

  // ------------------------------------------------------------------------
  // write side, cam_pclk
  // ------------------------------------------------------------------------
  assign wr_bin_nxt = wr_bin + 1'b1;
  assign full = (wr_gray == {~rg_sync[fifo_addr_w:fifo_addr_w-1], rg_sync[fifo_addr_w-2:0]});

  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n) begin
      wf_d0    <= 1'b0;
      wr_flush <= 1'b0;
      rg_d0    <= '0;
      rg_sync  <= '0;
      wr_bin   <= '0;
      wr_gray  <= '0;
      overflow <= 1'b0;
    end else begin
      wf_d0    <= flush_req;
      wr_flush <= wf_d0;
      rg_d0    <= rd_gray;      // read ptr into write domain
      rg_sync  <= rg_d0;
      overflow <= wr_en & full & ~wr_flush;  // dropped byte, one-cycle strobe
      if (wr_flush) begin
        wr_bin  <= '0;
        wr_gray <= '0;
      end else if (wr_en && !full) begin
        wr_bin  <= wr_bin_nxt;
        wr_gray <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
      end
    end
  end

  always_ff @(posedge cam_pclk) begin
    if (wr_en && !full && !wr_flush) mem[wr_bin[fifo_addr_w-1:0]] <= wr_data;
  end

  // ------------------------------------------------------------------------
  // read side, eth_tx_clk
  // ------------------------------------------------------------------------
  assign rd_bin_nxt = rd_bin + 1'b1;
  assign empty      = (rd_gray == wg_sync);

  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      rf_d0      <= 1'b0;
      rd_flush   <= 1'b0;
      wg_d0      <= '0;
      wg_sync    <= '0;
      rd_bin     <= '0;
      rd_gray    <= '0;
      fill_level <= '0;
    end else begin
      rf_d0    <= flush_req;
      rd_flush <= rf_d0;
      wg_d0    <= wr_gray;      // write ptr into read domain
      wg_sync  <= wg_d0;
      fill_level <= rd_flush ? '0 : gray2bin(wg_sync) - rd_bin;
      if (rd_flush) begin
        rd_bin  <= '0;
        rd_gray <= '0;
      end else if (rd_en && !empty) begin
        rd_bin  <= rd_bin_nxt;
        rd_gray <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      end
    end
  end

  // data one cycle after req
  always_ff @(posedge eth_tx_clk) begin
    if (rd_en && !empty) rd_data <= mem[rd_bin[fifo_addr_w-1:0]];
  end

endmodule

`default_nettype wire

// ==== verilog/img_ctrl_regs.sv ====
// aw and w must arrive together; response always OKAY, unmapped reads return 0, STATUS writes ignored
`default_nettype none
`timescale 1ns/1ps

module img_ctrl_regs (
  input  wire                                  cam_pclk,
  input  wire                                  rst_n,
  input  wire  [img_pkt_pkg::axil_addr_w-1:0]  s_axil_awaddr,
  input  wire                                  s_axil_awvalid,
  output logic                                 s_axil_awready,
  input  wire  [img_pkt_pkg::axil_data_w-1:0]  s_axil_wdata,
  input  wire  [img_pkt_pkg::axil_data_w/8-1:0] s_axil_wstrb,
  input  wire                                  s_axil_wvalid,
  output logic                                 s_axil_wready,
  output logic [1:0]                           s_axil_bresp,
  output logic                                 s_axil_bvalid,
  input  wire                                  s_axil_bready,
  input  wire  [img_pkt_pkg::axil_addr_w-1:0]  s_axil_araddr,
  input  wire                                  s_axil_arvalid,
  output logic                                 s_axil_arready,
  output logic [img_pkt_pkg::axil_data_w-1:0]  s_axil_rdata,
  output logic [1:0]                           s_axil_rresp,
  output logic                                 s_axil_rvalid,
  input  wire                                  s_axil_rready,
  input  wire                                  frame_start,
  input  wire                                  overflow,
  output logic                                 enable
);
  import img_pkt_pkg::*;

  logic [15:0]            frame_cnt;
  logic                   ovf_flag;
  logic                   wr_fire;     // both channels valid, not yet taken
  logic                   wr_hs;
  logic                   ctrl_wr;
  logic                   rd_fire;
  logic                   rd_hs;
  logic [axil_data_w-1:0] ctrl_word;
  logic [axil_data_w-1:0] status_word;

  assign s_axil_bresp = 2'b00;
  assign s_axil_rresp = 2'b00;

  // ------------------------------------------------------------------------
  // write channel
  // ------------------------------------------------------------------------
  assign wr_fire = s_axil_awvalid & s_axil_wvalid & ~s_axil_awready & ~s_axil_bvalid;
  assign wr_hs   = s_axil_awready & s_axil_awvalid & s_axil_wvalid;
  assign ctrl_wr = wr_hs & (s_axil_awaddr == reg_ctrl_addr) & s_axil_wstrb[0];

  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axil_awready <= 1'b0;
      s_axil_wready  <= 1'b0;
      s_axil_bvalid  <= 1'b0;
    end else begin
      s_axil_awready <= wr_fire;   // aw and w taken in the same cycle
      s_axil_wready  <= wr_fire;
      if (wr_hs)
        s_axil_bvalid <= 1'b1;
      else if (s_axil_bready)
        s_axil_bvalid <= 1'b0;     // held until bready
    end
  end

  // ------------------------------------------------------------------------
  // read channel
  // ------------------------------------------------------------------------
  assign rd_fire = s_axil_arvalid & ~s_axil_arready & ~s_axil_rvalid;
  assign rd_hs   = s_axil_arready & s_axil_arvalid;

  always_comb begin
    ctrl_word                                  = '0;
    ctrl_word[ctrl_enable_bit]                 = enable;
    status_word                                = '0;
    status_word[status_cnt_msb:status_cnt_lsb] = frame_cnt;
    status_word[status_ovf_bit]                = ovf_flag;
  end

  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axil_arready <= 1'b0;
      s_axil_rvalid  <= 1'b0;
    end else begin
      s_axil_arready <= rd_fire;
      if (rd_hs)
        s_axil_rvalid <= 1'b1;
      else if (s_axil_rready)
        s_axil_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge cam_pclk) begin
    if (rd_hs) begin
      case (s_axil_araddr)
        reg_ctrl_addr:   s_axil_rdata <= ctrl_word;
        reg_status_addr: s_axil_rdata <= status_word;
        default:         s_axil_rdata <= '0;
      endcase
    end
  end

  // ------------------------------------------------------------------------
  // register state
  // ------------------------------------------------------------------------
  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n) begin
      enable    <= 1'b0;
      frame_cnt <= 16'd0;
      ovf_flag  <= 1'b0;
    end else begin
      if (ctrl_wr) enable <= s_axil_wdata[ctrl_enable_bit];
      if (frame_start) frame_cnt <= frame_cnt + 16'd1;  // wraps
      // set wins over a clear in the same cycle
      if (overflow)
        ovf_flag <= 1'b1;
      else if (ctrl_wr && s_axil_wdata[ctrl_ovf_clear_bit])
        ovf_flag <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/img_frame_framer.sv ====
// vsync high = blanking; camera must stay idle >= 12 pclk after vsync falls, header overrides pixels
`default_nettype none
`timescale 1ns/1ps

module img_frame_framer #(
  parameter logic [15:0] h_pixel = 16'd640,
  parameter logic [15:0] v_pixel = 16'd480
) (
  input  wire        cam_pclk,
  input  wire        rst_n,
  input  wire        img_vsync,
  input  wire        img_data_en,
  input  wire  [7:0] img_data,
  input  wire        enable,
  output logic       wr_en,
  output logic [7:0] wr_data,
  output logic       flush_req,
  output logic       frame_start
);
  import img_pkt_pkg::*;

  logic       vs_d0;      // metastability stage
  logic       vs_d1;      // synced vsync
  logic       vs_d2;      // edge reference
  logic       neg_vsync;
  logic [3:0] hdr_cnt;    // saturates at hdr_bytes
  logic       hdr_act;
  logic [7:0] hdr_byte;
  logic       data_en_d0;
  logic [7:0] data_d0;

  // ------------------------------------------------------------------------
  // vsync sync + edge detect
  // ------------------------------------------------------------------------
  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n) begin
      vs_d0 <= 1'b0;
      vs_d1 <= 1'b0;
      vs_d2 <= 1'b0;
    end else begin
      vs_d0 <= img_vsync;
      vs_d1 <= vs_d0;
      vs_d2 <= vs_d1;
    end
  end

  assign neg_vsync = vs_d2 & ~vs_d1;    // end of blanking
  assign flush_req = vs_d1 | ~enable;   // fifo held empty in blanking or when off

  // frame start pulse, enabled frames only
  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n) frame_start <= 1'b0;
    else        frame_start <= neg_vsync & enable;
  end

  // ------------------------------------------------------------------------
  // header sequencing
  // ------------------------------------------------------------------------
  assign hdr_act = (hdr_cnt < 4'(hdr_bytes));

  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n)                  hdr_cnt <= 4'(hdr_bytes); // idle
    else if (neg_vsync && enable) hdr_cnt <= 4'd0;
    else if (hdr_act)            hdr_cnt <= hdr_cnt + 4'd1;
  end

  always_comb begin
    case (hdr_cnt[2:0])
      3'd0:    hdr_byte = frame_marker[31:24];
      3'd1:    hdr_byte = frame_marker[23:16];
      3'd2:    hdr_byte = frame_marker[15:8];
      3'd3:    hdr_byte = frame_marker[7:0];
      3'd4:    hdr_byte = h_pixel[15:8];       // h size, big endian
      3'd5:    hdr_byte = h_pixel[7:0];
      3'd6:    hdr_byte = v_pixel[15:8];       // v size
      default: hdr_byte = v_pixel[7:0];
    endcase
  end

  // ------------------------------------------------------------------------
  // pixel stage + merged write path
  // ------------------------------------------------------------------------
  always_ff @(posedge cam_pclk or negedge rst_n) begin
    if (!rst_n) begin
      data_en_d0 <= 1'b0;
      wr_en      <= 1'b0;
    end else begin
      data_en_d0 <= img_data_en;
      wr_en      <= hdr_act | data_en_d0;
    end
  end

  always_ff @(posedge cam_pclk) begin
    data_d0 <= img_data;
    wr_data <= hdr_act ? hdr_byte : data_d0; // pixels under the header are lost
  end

endmodule

`default_nettype wire

// ==== verilog/img_pkt_pkg.sv ====
// shared constants only; the register map assumes a 4-bit axi4-lite word address space
`default_nettype none

package img_pkt_pkg;

  // ------------------------------------------------------------------------
  // frame header
  // ------------------------------------------------------------------------
  localparam logic [31:0] frame_marker    = 32'hf05a_a50f; // sent msb first
  localparam int unsigned hdr_bytes       = 8;             // marker + h size + v size
  localparam int unsigned bytes_per_pixel = 2;             // no format conversion

  // ------------------------------------------------------------------------
  // axi4-lite register map
  // ------------------------------------------------------------------------
  localparam int unsigned axil_addr_w = 4;
  localparam int unsigned axil_data_w = 32;

  localparam logic [axil_addr_w-1:0] reg_ctrl_addr   = 4'h0;
  localparam logic [axil_addr_w-1:0] reg_status_addr = 4'h4; // read only

  // ctrl bits
  localparam int unsigned ctrl_enable_bit    = 0;
  localparam int unsigned ctrl_ovf_clear_bit = 1; // write 1 clears, reads back 0

  // status fields
  localparam int unsigned status_ovf_bit = 0;  // sticky
  localparam int unsigned status_cnt_lsb = 16; // frame counter, wraps
  localparam int unsigned status_cnt_msb = 31;

endpackage

`default_nettype wire

// ==== verilog/img_udp_top.sv ====
// two bytes per pixel; fifo must hold header plus one line; udp/ip engine lives outside
`default_nettype none
`timescale 1ns/1ps

module img_udp_top #(
  parameter logic [15:0] h_pixel     = 16'd640,
  parameter logic [15:0] v_pixel     = 16'd480,
  parameter int unsigned fifo_addr_w = 11
) (
  input  wire                                   cam_pclk,
  input  wire                                   eth_tx_clk,
  input  wire                                   rst_n,
  // camera
  input  wire                                   img_vsync,
  input  wire                                   img_data_en,
  input  wire  [7:0]                            img_data,
  // udp engine
  input  wire                                   udp_tx_req,
  input  wire                                   udp_tx_done,
  output logic                                  udp_tx_start_en,
  output logic [7:0]                            udp_tx_data,
  output logic [15:0]                           udp_tx_byte_num,
  // axi4-lite control
  input  wire  [img_pkt_pkg::axil_addr_w-1:0]   s_axil_awaddr,
  input  wire                                   s_axil_awvalid,
  output logic                                  s_axil_awready,
  input  wire  [img_pkt_pkg::axil_data_w-1:0]   s_axil_wdata,
  input  wire  [img_pkt_pkg::axil_data_w/8-1:0] s_axil_wstrb,
  input  wire                                   s_axil_wvalid,
  output logic                                  s_axil_wready,
  output logic [1:0]                            s_axil_bresp,
  output logic                                  s_axil_bvalid,
  input  wire                                   s_axil_bready,
  input  wire  [img_pkt_pkg::axil_addr_w-1:0]   s_axil_araddr,
  input  wire                                   s_axil_arvalid,
  output logic                                  s_axil_arready,
  output logic [img_pkt_pkg::axil_data_w-1:0]   s_axil_rdata,
  output logic [1:0]                            s_axil_rresp,
  output logic                                  s_axil_rvalid,
  input  wire                                   s_axil_rready
);
  logic                 enable;
  logic                 frame_start;
  logic                 wr_en;
  logic [7:0]           wr_data;
  logic                 flush_req;
  logic                 overflow;
  logic [fifo_addr_w:0] fill_level;
  logic                 rd_flush;

  img_frame_framer #(.h_pixel(h_pixel), .v_pixel(v_pixel)) i_framer (
    .cam_pclk, .rst_n, .img_vsync, .img_data_en, .img_data, .enable,
    .wr_en, .wr_data, .flush_req, .frame_start
  );

  img_async_fifo #(.fifo_addr_w(fifo_addr_w)) i_fifo (
    .cam_pclk, .eth_tx_clk, .rst_n, .flush_req, .wr_en, .wr_data, .overflow,
    .rd_en(udp_tx_req), .rd_data(udp_tx_data), .fill_level, .rd_flush
  );

  udp_pkt_sched #(.h_pixel(h_pixel), .fifo_addr_w(fifo_addr_w)) i_sched (
    .eth_tx_clk, .rst_n, .fill_level, .rd_flush, .udp_tx_done,
    .udp_tx_start_en, .udp_tx_byte_num
  );

  img_ctrl_regs i_regs (
    .cam_pclk, .rst_n,
    .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
    .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
    .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
    .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
    .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
    .frame_start, .overflow, .enable
  );

endmodule

`default_nettype wire

// ==== verilog/udp_pkt_sched.sv ====
// one packet outstanding at a time; the engine must read exactly udp_tx_byte_num bytes per start
`default_nettype none
`timescale 1ns/1ps

module udp_pkt_sched #(
  parameter logic [15:0] h_pixel     = 16'd640,
  parameter int unsigned fifo_addr_w = 11
) (
  input  wire                  eth_tx_clk,
  input  wire                  rst_n,
  input  wire [fifo_addr_w:0]  fill_level,
  input  wire                  rd_flush,
  input  wire                  udp_tx_done,
  output logic                 udp_tx_start_en,
  output logic [15:0]          udp_tx_byte_num
);
  import img_pkt_pkg::*;

  localparam logic [15:0] line_bytes  = 16'(h_pixel * bytes_per_pixel);
  localparam logic [15:0] first_bytes = 16'(line_bytes + hdr_bytes); // header + line

  logic rd_flush_d;
  logic flush_rise;   // frame aborted / blanking
  logic flush_fall;   // new frame
  logic busy;
  logic enough;
  logic go;

  assign flush_rise = ~rd_flush_d & rd_flush;
  assign flush_fall = rd_flush_d & ~rd_flush;

  // zero count only right after reset
  assign enough = (16'(fill_level) >= udp_tx_byte_num) && (udp_tx_byte_num != 16'd0);
  assign go     = ~busy & ~rd_flush & enough;

  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) rd_flush_d <= 1'b0;
    else        rd_flush_d <= rd_flush;
  end

  // ------------------------------------------------------------------------
  // packet length
  // ------------------------------------------------------------------------
  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n)           udp_tx_byte_num <= 16'd0;
    else if (flush_fall)  udp_tx_byte_num <= first_bytes;
    else if (udp_tx_done) udp_tx_byte_num <= line_bytes;  // rest of frame, one line each
  end

  // ------------------------------------------------------------------------
  // start strobe + busy
  // ------------------------------------------------------------------------
  always_ff @(posedge eth_tx_clk or negedge rst_n) begin
    if (!rst_n) begin
      udp_tx_start_en <= 1'b0;
      busy            <= 1'b0;
    end else begin
      udp_tx_start_en <= go;                 // single pulse, busy blocks the next
      if (go)
        busy <= 1'b1;
      else if (udp_tx_done || flush_rise)
        busy <= 1'b0;
    end
  end

endmodule

`default_nettype wire
